// File: common/sound_cfg.svh
`ifndef SOUND_CFG_SVH
`define SOUND_CFG_SVH

// Widths.
`define SND_DATA_W    8
`define SND_SAMPLE_W  8
`define SND_VOL_W     4
`define SND_ADDR_W    8
`define SND_AXI_W     32

// Register map, byte addresses.
`define SND_SQ_PERIOD 8'h00
`define SND_SQ_CTRL   8'h04
`define SND_SQ_LEN    8'h08
`define SND_NZ_PERIOD 8'h0C
`define SND_NZ_CTRL   8'h10
`define SND_NZ_LEN    8'h14
`define SND_NR50      8'h18
`define SND_NR51      8'h1C
`define SND_NR52      8'h20

// AXI responses.
`define SND_RESP_OKAY   2'b00
`define SND_RESP_SLVERR 2'b10

// Noise generator.
`define SND_LFSR_W    15
`define SND_LFSR_SEED 15'h7FFF

`endif

// File: common/sound_pkg.sv
`include "sound_cfg.svh"

package sound_pkg;

   // One output sample, unsigned.
   typedef logic [`SND_SAMPLE_W-1:0] sample_t;

   // Register byte address.
   typedef logic [`SND_ADDR_W-1:0] reg_addr_t;

   // Per channel status for the mixer and NR52.
   typedef struct packed {
      logic on;
      logic active_high;
   } chan_status_t;

endpackage

// File: common/reg_bus_if.sv
`timescale 1ns/1ps
`include "sound_cfg.svh"

interface reg_bus_if;
   import sound_pkg::*;

   logic                   wr_en;
   reg_addr_t              addr;
   logic [`SND_DATA_W-1:0] wdata;
   logic                   rd_en;
   logic [`SND_DATA_W-1:0] rdata;
   // Set when addr falls in the device window.
   logic                   hit;

   modport host (
      output wr_en,
      output addr,
      output wdata,
      output rd_en,
      input  rdata,
      input  hit
   );

   modport dev (
      input  wr_en,
      input  addr,
      input  wdata,
      input  rd_en,
      output rdata,
      output hit
   );

endinterface

// File: source/sound_regs.sv
`timescale 1ns/1ps
`include "sound_cfg.svh"

module sound_regs (
   input  logic                      clk,
   input  logic                      arst_n,
   input  sound_pkg::reg_addr_t      awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [`SND_AXI_W-1:0]     wdata,
   input  logic [`SND_AXI_W/8-1:0]   wstrb,
   input  logic                      wvalid,
   output logic                      wready,
   output logic [1:0]                bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  sound_pkg::reg_addr_t      araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output logic [`SND_AXI_W-1:0]     rdata,
   output logic [1:0]                rresp,
   output logic                      rvalid,
   input  logic                      rready,
   reg_bus_if.host                   sq_bus,
   reg_bus_if.host                   nz_bus,
   input  sound_pkg::chan_status_t   sq_status,
   input  sound_pkg::chan_status_t   nz_status,
   output logic [`SND_DATA_W-1:0]    nr50,
   output logic [`SND_DATA_W-1:0]    nr51,
   output logic                      master_en
);

   logic                   wr_take;
   logic                   rd_take;
   logic [`SND_ADDR_W-1:0] bus_addr;
   logic                   glob_hit;
   logic                   any_hit;
   logic [`SND_DATA_W-1:0] glob_rdata;
   logic [`SND_DATA_W-1:0] rd_byte;

   assign awready = !bvalid;
   assign wready  = !bvalid;
   assign wr_take = awvalid && wvalid && !bvalid;

   // A write in the same cycle holds the read off for one cycle.
   assign arready = !rvalid && !wr_take;
   assign rd_take = arvalid && arready;

   // One address serves both directions.
   assign bus_addr = wr_take ? awaddr : araddr;

   assign sq_bus.addr  = bus_addr;
   assign sq_bus.wdata = wdata[`SND_DATA_W-1:0];
   assign sq_bus.wr_en = wr_take && wstrb[0];
   assign sq_bus.rd_en = rd_take;
   assign nz_bus.addr  = bus_addr;
   assign nz_bus.wdata = wdata[`SND_DATA_W-1:0];
   assign nz_bus.wr_en = wr_take && wstrb[0];
   assign nz_bus.rd_en = rd_take;

   // Global registers.
   always_comb begin
      glob_hit   = 1'b1;
      glob_rdata = '0;
      case (bus_addr)
         `SND_NR50: glob_rdata = nr50;
         `SND_NR51: glob_rdata = nr51;
         `SND_NR52: glob_rdata = {master_en, {(`SND_DATA_W-3){1'b0}},
                                  nz_status.on, sq_status.on};
         default:   glob_hit = 1'b0;
      endcase
   end

   assign any_hit = glob_hit || sq_bus.hit || nz_bus.hit;
   assign rd_byte = glob_hit    ? glob_rdata :
                    sq_bus.hit  ? sq_bus.rdata :
                    nz_bus.hit  ? nz_bus.rdata : '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         nr50      <= '0;
         nr51      <= '0;
         master_en <= 1'b0;
      end else if (wr_take && wstrb[0]) begin
         case (awaddr)
            `SND_NR50: nr50 <= wdata[`SND_DATA_W-1:0];
            `SND_NR51: nr51 <= wdata[`SND_DATA_W-1:0];
            // Only the master bit is writable.
            `SND_NR52: master_en <= wdata[`SND_DATA_W-1];
            default: ;
         endcase
      end
   end

   // Write response.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bvalid <= 1'b0;
      end else if (wr_take) begin
         bvalid <= 1'b1;
      end else if (bready) begin
         bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_take) begin
         bresp <= any_hit ? `SND_RESP_OKAY : `SND_RESP_SLVERR;
      end
   end

   // Read response.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rvalid <= 1'b0;
      end else if (rd_take) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_take) begin
         rdata <= {{(`SND_AXI_W-`SND_DATA_W){1'b0}}, rd_byte};
         rresp <= any_hit ? `SND_RESP_OKAY : `SND_RESP_SLVERR;
      end
   end

   bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      bvalid && !bready |=> bvalid);

   rdata_hold: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: square_channel/square_channel.sv
`timescale 1ns/1ps
`include "sound_cfg.svh"

module square_channel (
   input  logic                    clk,
   input  logic                    arst_n,
   reg_bus_if.dev                  bus,
   output sound_pkg::sample_t      sample,
   output sound_pkg::chan_status_t status
);

   logic [`SND_DATA_W-1:0] period;
   logic [`SND_DATA_W-1:0] ctrl;
   logic [`SND_DATA_W-1:0] len;
   logic [`SND_DATA_W-1:0] div_cnt;
   logic [`SND_DATA_W-1:0] len_cnt;
   logic [2:0]             step;
   logic [2:0]             high_steps;
   logic                   on;
   logic                   trigger;
   logic                   tick;

   assign bus.hit = (bus.addr == `SND_SQ_PERIOD) || (bus.addr == `SND_SQ_CTRL) ||
                    (bus.addr == `SND_SQ_LEN);

   always_comb begin
      bus.rdata = '0;
      if (bus.rd_en) begin
         case (bus.addr)
            `SND_SQ_PERIOD: bus.rdata = period;
            `SND_SQ_CTRL:   bus.rdata = ctrl;
            `SND_SQ_LEN:    bus.rdata = len;
            default:        bus.rdata = '0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         period <= '0;
         ctrl   <= '0;
         len    <= '0;
      end else if (bus.wr_en) begin
         case (bus.addr)
            `SND_SQ_PERIOD: period <= bus.wdata;
            `SND_SQ_CTRL:   ctrl   <= bus.wdata;
            `SND_SQ_LEN:    len    <= bus.wdata;
            default: ;
         endcase
      end
   end

   assign trigger = bus.wr_en && (bus.addr == `SND_SQ_CTRL) && bus.wdata[7];
   assign tick    = on && (div_cnt >= period);

   // Divider, step and length counter.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         on      <= 1'b0;
         div_cnt <= '0;
         step    <= '0;
         len_cnt <= '0;
      end else if (trigger) begin
         on      <= 1'b1;
         div_cnt <= '0;
         step    <= '0;
         len_cnt <= len;
      end else if (tick) begin
         div_cnt <= '0;
         step    <= step + 3'd1;
         // Zero length runs forever.
         if (len_cnt != '0) begin
            len_cnt <= len_cnt - 1'b1;
            if (len_cnt == 1) begin
               on <= 1'b0;
            end
         end
      end else if (on) begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   always_comb begin
      case (ctrl[5:4])
         2'd0:    high_steps = 3'd1;
         2'd1:    high_steps = 3'd2;
         2'd2:    high_steps = 3'd4;
         default: high_steps = 3'd6;
      endcase
   end

   assign sample = (on && (step < high_steps)) ?
                   {{(`SND_SAMPLE_W-`SND_VOL_W){1'b0}}, ctrl[`SND_VOL_W-1:0]} : '0;

   assign status.on          = on;
   assign status.active_high = (sample != '0);

   silent_when_off: assert property (@(posedge clk) disable iff (!arst_n)
      !status.on |-> sample == '0);

endmodule

// File: noise_channel/noise_channel.sv
`timescale 1ns/1ps
`include "sound_cfg.svh"

module noise_channel (
   input  logic                    clk,
   input  logic                    arst_n,
   reg_bus_if.dev                  bus,
   output sound_pkg::sample_t      sample,
   output sound_pkg::chan_status_t status
);

   logic [`SND_DATA_W-1:0] period;
   logic [`SND_DATA_W-1:0] ctrl;
   logic [`SND_DATA_W-1:0] len;
   logic [`SND_DATA_W-1:0] div_cnt;
   logic [`SND_DATA_W-1:0] len_cnt;
   logic [`SND_LFSR_W-1:0] lfsr;
   logic                   on;
   logic                   trigger;
   logic                   tick;

   assign bus.hit = (bus.addr == `SND_NZ_PERIOD) || (bus.addr == `SND_NZ_CTRL) ||
                    (bus.addr == `SND_NZ_LEN);

   always_comb begin
      bus.rdata = '0;
      if (bus.rd_en) begin
         case (bus.addr)
            `SND_NZ_PERIOD: bus.rdata = period;
            `SND_NZ_CTRL:   bus.rdata = ctrl;
            `SND_NZ_LEN:    bus.rdata = len;
            default:        bus.rdata = '0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         period <= '0;
         ctrl   <= '0;
         len    <= '0;
      end else if (bus.wr_en) begin
         case (bus.addr)
            `SND_NZ_PERIOD: period <= bus.wdata;
            `SND_NZ_CTRL:   ctrl   <= bus.wdata;
            `SND_NZ_LEN:    len    <= bus.wdata;
            default: ;
         endcase
      end
   end

   assign trigger = bus.wr_en && (bus.addr == `SND_NZ_CTRL) && bus.wdata[7];
   assign tick    = on && (div_cnt >= period);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         on      <= 1'b0;
         div_cnt <= '0;
         lfsr    <= '0;
         len_cnt <= '0;
      end else if (trigger) begin
         on      <= 1'b1;
         div_cnt <= '0;
         lfsr    <= `SND_LFSR_SEED;
         len_cnt <= len;
      end else if (tick) begin
         div_cnt <= '0;
         // Feedback from taps 0 and 1 into the top bit.
         lfsr    <= {lfsr[0] ^ lfsr[1], lfsr[`SND_LFSR_W-1:1]};
         if (len_cnt != '0) begin
            len_cnt <= len_cnt - 1'b1;
            if (len_cnt == 1) begin
               on <= 1'b0;
            end
         end
      end else if (on) begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   assign sample = (on && !lfsr[0]) ?
                   {{(`SND_SAMPLE_W-`SND_VOL_W){1'b0}}, ctrl[`SND_VOL_W-1:0]} : '0;

   assign status.on          = on;
   assign status.active_high = (sample != '0);

   lfsr_not_stuck: assert property (@(posedge clk) disable iff (!arst_n)
      on |-> lfsr != '0);

endmodule

// File: source/sound_mixer.sv
`timescale 1ns/1ps
`include "sound_cfg.svh"

module sound_mixer (
   input  logic                   clk,
   input  logic                   arst_n,
   input  sound_pkg::sample_t     sq_sample,
   input  sound_pkg::sample_t     nz_sample,
   input  logic [`SND_DATA_W-1:0] nr50,
   input  logic [`SND_DATA_W-1:0] nr51,
   input  logic                   master_en,
   output sound_pkg::sample_t     so1,
   output sound_pkg::sample_t     so2
);
   import sound_pkg::*;

   sample_t so1_sum;
   sample_t so2_sum;
   logic    so1_en;
   logic    so2_en;

   // Routing from NR51.
   assign so1_sum = (nr51[0] ? sq_sample : '0) + (nr51[1] ? nz_sample : '0);
   assign so2_sum = (nr51[4] ? sq_sample : '0) + (nr51[5] ? nz_sample : '0);

   // NR50 volume bits are not used, only the output enables.
   assign so1_en = master_en && nr50[3];
   assign so2_en = master_en && nr50[7];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         so1 <= '0;
         so2 <= '0;
      end else begin
         so1 <= so1_en ? so1_sum : '0;
         so2 <= so2_en ? so2_sum : '0;
      end
   end

   muted_when_off: assert property (@(posedge clk) disable iff (!arst_n)
      !master_en |=> (so1 == '0) && (so2 == '0));

endmodule

// File: source/sound_controller.sv
`timescale 1ns/1ps
`include "sound_cfg.svh"

module sound_controller (
   input  logic                    clk,
   input  logic                    arst_n,
   input  sound_pkg::reg_addr_t    awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [`SND_AXI_W-1:0]   wdata,
   input  logic [`SND_AXI_W/8-1:0] wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  sound_pkg::reg_addr_t    araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [`SND_AXI_W-1:0]   rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,
   output sound_pkg::sample_t      so1,
   output sound_pkg::sample_t      so2
);
   import sound_pkg::*;

   sample_t                sq_sample;
   sample_t                nz_sample;
   chan_status_t           sq_status;
   chan_status_t           nz_status;
   logic [`SND_DATA_W-1:0] nr50;
   logic [`SND_DATA_W-1:0] nr51;
   logic                   master_en;

   reg_bus_if sq_bus ();
   reg_bus_if nz_bus ();

   sound_regs regs_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .sq_bus    (sq_bus),
      .nz_bus    (nz_bus),
      .sq_status (sq_status),
      .nz_status (nz_status),
      .nr50      (nr50),
      .nr51      (nr51),
      .master_en (master_en)
   );

   square_channel square_i (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (sq_bus),
      .sample (sq_sample),
      .status (sq_status)
   );

   noise_channel noise_i (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (nz_bus),
      .sample (nz_sample),
      .status (nz_status)
   );

   sound_mixer mixer_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .sq_sample (sq_sample),
      .nz_sample (nz_sample),
      .nr50      (nr50),
      .nr51      (nr51),
      .master_en (master_en),
      .so1       (so1),
      .so2       (so2)
   );

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
   parameter real PERIOD_NS    = 100.0,
   parameter int  RESET_CYCLES = 16
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

   // Release away from the clock edge.
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #10;
      arst_n = 1'b1;
   end

endmodule

// File: verif/sound_tb.sv
`timescale 1ns/1ps
`include "sound_cfg.svh"

module sound_tb;
   import sound_pkg::*;

   // Tests take roughly 600 cycles.
   localparam int WATCHDOG_CYCLES = 4000;
   localparam int M_IDLE      = 0;
   localparam int M_SQUARE    = 1;
   localparam int M_MIX       = 2;
   localparam int SQ_PERIOD_I = `SND_SQ_PERIOD >> 2;
   localparam int SQ_CTRL_I   = `SND_SQ_CTRL >> 2;
   localparam int SQ_LEN_I    = `SND_SQ_LEN >> 2;
   localparam int NZ_PERIOD_I = `SND_NZ_PERIOD >> 2;
   localparam int NZ_CTRL_I   = `SND_NZ_CTRL >> 2;
   localparam int NZ_LEN_I    = `SND_NZ_LEN >> 2;
   localparam int NR50_I      = `SND_NR50 >> 2;
   localparam int NR52_I      = `SND_NR52 >> 2;

   logic                    clk;
   logic                    arst_n;
   reg_addr_t               awaddr;
   logic                    awvalid;
   logic                    awready;
   logic [`SND_AXI_W-1:0]   wdata;
   logic [`SND_AXI_W/8-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;
   logic [1:0]              bresp;
   logic                    bvalid;
   logic                    bready;
   reg_addr_t               araddr;
   logic                    arvalid;
   logic                    arready;
   logic [`SND_AXI_W-1:0]   rdata;
   logic [1:0]              rresp;
   logic                    rvalid;
   logic                    rready;
   sample_t                 so1;
   sample_t                 so2;

   integer                  seed = 32'h0ec5550b;
   int                      mode;
   logic [7:0]              shadow [9];
   logic                    sq_on_m;
   logic                    nz_on_m;
   int                      sq_left;
   int                      nz_left;
   logic                    b_pend_m;
   logic                    r_pend_m;
   logic [`SND_AXI_W-1:0]   exp_rdata;
   logic [1:0]              exp_rresp;
   logic [1:0]              exp_bresp;
   logic [`SND_AXI_W-1:0]   rdata_q;
   sample_t                 so1_q;
   sample_t                 so2_q;
   logic                    seen_rise;
   int                      since_rise;
   int                      high_len;
   int                      mix_cycles;
   int                      so2_changes;
   logic                    nz_heard;
   logic                    wr_hs;
   logic                    rd_hs;
   logic                    sq_trig;
   logic                    nz_trig;
   logic                    so1_rise;
   logic                    so1_fall;
   sample_t                 sq_vol;
   sample_t                 nz_vol;
   int                      exp_gap;
   int                      exp_high;

   clk_gen #(.PERIOD_NS(100.0), .RESET_CYCLES(16)) clk_gen_i (
      .clk    (clk),
      .arst_n (arst_n)
   );

   sound_controller dut_i (.*);

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Something failed");
      $fatal(1);
   endtask

   function automatic logic is_mapped(input reg_addr_t addr);
      return (addr[1:0] == 2'b00) && (addr <= `SND_NR52);
   endfunction

   // High steps out of eight per duty setting.
   function automatic int duty_steps(input logic [1:0] duty);
      case (duty)
         2'd0:    return 1;
         2'd1:    return 2;
         2'd2:    return 4;
         default: return 6;
      endcase
   endfunction

   function automatic logic [7:0] read_value(input reg_addr_t addr);
      if (!is_mapped(addr)) begin
         return 8'h00;
      end
      if (addr == `SND_NR52) begin
         return {shadow[NR52_I][7], 5'b00000, nz_on_m, sq_on_m};
      end
      return shadow[addr[7:2]];
   endfunction

   assign wr_hs    = awvalid && wvalid && awready;
   assign rd_hs    = arvalid && arready;
   assign sq_trig  = wr_hs && wstrb[0] && (awaddr == `SND_SQ_CTRL) && wdata[7];
   assign nz_trig  = wr_hs && wstrb[0] && (awaddr == `SND_NZ_CTRL) && wdata[7];
   assign so1_rise = (so1 != '0) && (so1_q == '0);
   assign so1_fall = (so1 == '0) && (so1_q != '0);
   assign sq_vol   = {4'h0, shadow[SQ_CTRL_I][3:0]};
   assign nz_vol   = {4'h0, shadow[NZ_CTRL_I][3:0]};
   assign exp_gap  = 8 * (int'(shadow[SQ_PERIOD_I]) + 1);
   assign exp_high = duty_steps(shadow[SQ_CTRL_I][5:4]) * (int'(shadow[SQ_PERIOD_I]) + 1);

   // Shadow registers, pending responses and channel on flags.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 9; i++) begin
            shadow[i] <= '0;
         end
         sq_on_m   <= 1'b0;
         nz_on_m   <= 1'b0;
         sq_left   <= 0;
         nz_left   <= 0;
         b_pend_m  <= 1'b0;
         r_pend_m  <= 1'b0;
         exp_rdata <= '0;
         exp_rresp <= `SND_RESP_OKAY;
         exp_bresp <= `SND_RESP_OKAY;
      end else begin
         if (wr_hs) begin
            b_pend_m  <= 1'b1;
            exp_bresp <= is_mapped(awaddr) ? `SND_RESP_OKAY : `SND_RESP_SLVERR;
            if (wstrb[0] && is_mapped(awaddr)) begin
               shadow[awaddr[7:2]] <= wdata[7:0];
            end
         end else if (bready) begin
            b_pend_m <= 1'b0;
         end
         if (rd_hs) begin
            r_pend_m  <= 1'b1;
            exp_rdata <= {24'h000000, read_value(araddr)};
            exp_rresp <= is_mapped(araddr) ? `SND_RESP_OKAY : `SND_RESP_SLVERR;
         end else if (rready) begin
            r_pend_m <= 1'b0;
         end
         // Zero length never expires.
         if (sq_trig) begin
            sq_on_m <= 1'b1;
            sq_left <= int'(shadow[SQ_LEN_I]) * (int'(shadow[SQ_PERIOD_I]) + 1);
         end else if (sq_on_m && sq_left != 0) begin
            sq_left <= sq_left - 1;
            if (sq_left == 1) begin
               sq_on_m <= 1'b0;
            end
         end
         if (nz_trig) begin
            nz_on_m <= 1'b1;
            nz_left <= int'(shadow[NZ_LEN_I]) * (int'(shadow[NZ_PERIOD_I]) + 1);
         end else if (nz_on_m && nz_left != 0) begin
            nz_left <= nz_left - 1;
            if (nz_left == 1) begin
               nz_on_m <= 1'b0;
            end
         end
      end
   end

   // Output history for the waveform checks.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata_q     <= '0;
         so1_q       <= '0;
         so2_q       <= '0;
         seen_rise   <= 1'b0;
         since_rise  <= 0;
         high_len    <= 0;
         mix_cycles  <= 0;
         so2_changes <= 0;
         nz_heard    <= 1'b0;
      end else begin
         rdata_q    <= rdata;
         so1_q      <= so1;
         so2_q      <= so2;
         seen_rise  <= (mode == M_SQUARE) && (seen_rise || so1_rise);
         since_rise <= so1_rise ? 1 : since_rise + 1;
         high_len   <= so1_rise ? 1 : ((so1 != '0) ? high_len + 1 : high_len);
         if (mode != M_MIX) begin
            mix_cycles  <= 0;
            so2_changes <= 0;
            nz_heard    <= 1'b0;
         end else begin
            mix_cycles <= mix_cycles + 1;
            if (so2 != so2_q) begin
               so2_changes <= so2_changes + 1;
            end
            if (so2 == nz_vol || so2 == sq_vol + nz_vol) begin
               nz_heard <= 1'b1;
            end
         end
      end
   end

   wr_flow_ok: assert property (@(posedge clk) disable iff (!arst_n)
      bvalid == b_pend_m && awready == !b_pend_m && wready == !b_pend_m)
      else report_fail($sformatf("FAIL bvalid awready wready expected %h %h %h actual %h %h %h",
                                 $sampled(b_pend_m), $sampled(!b_pend_m), $sampled(!b_pend_m),
                                 $sampled(bvalid), $sampled(awready), $sampled(wready)));

   // A write handshake may hold the read address channel off.
   rd_flow_ok: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid == r_pend_m && (r_pend_m ? !arready : (arready || wr_hs)))
      else report_fail($sformatf("FAIL rvalid arready expected %h %h actual %h %h",
                                 $sampled(r_pend_m), $sampled(!r_pend_m),
                                 $sampled(rvalid), $sampled(arready)));

   bresp_ok: assert property (@(posedge clk) disable iff (!arst_n)
      bvalid && bready |-> bresp == exp_bresp)
      else report_fail($sformatf("FAIL bresp expected %h actual %h",
                                 $sampled(exp_bresp), $sampled(bresp)));

   rdata_ok: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && rready |-> rdata == exp_rdata)
      else report_fail($sformatf("FAIL rdata expected %h actual %h",
                                 $sampled(exp_rdata), $sampled(rdata)));

   rresp_ok: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && rready |-> rresp == exp_rresp)
      else report_fail($sformatf("FAIL rresp expected %h actual %h",
                                 $sampled(exp_rresp), $sampled(rresp)));

   rdata_held: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && rdata == rdata_q)
      else report_fail($sformatf("FAIL rdata expected %h actual %h with rvalid %h",
                                 $sampled(rdata_q), $sampled(rdata), $sampled(rvalid)));

   sq_levels: assert property (@(posedge clk) disable iff (!arst_n)
      mode == M_SQUARE |-> so1 == '0 || so1 == sq_vol)
      else report_fail($sformatf("FAIL so1 expected 00 or %h actual %h",
                                 $sampled(sq_vol), $sampled(so1)));

   sq_gap: assert property (@(posedge clk) disable iff (!arst_n)
      mode == M_SQUARE && seen_rise && so1_rise |-> since_rise == exp_gap)
      else report_fail($sformatf("FAIL so1 rise gap expected %h actual %h",
                                 $sampled(exp_gap), $sampled(since_rise)));

   sq_high: assert property (@(posedge clk) disable iff (!arst_n)
      mode == M_SQUARE && seen_rise && so1_fall |-> high_len == exp_high)
      else report_fail($sformatf("FAIL so1 high time expected %h actual %h",
                                 $sampled(exp_high), $sampled(high_len)));

   mix_levels: assert property (@(posedge clk) disable iff (!arst_n)
      mode == M_MIX |-> so2 == '0 || so2 == sq_vol || so2 == nz_vol ||
                        so2 == sq_vol + nz_vol)
      else report_fail($sformatf("FAIL so2 expected 00, %h, %h or %h actual %h",
                                 $sampled(sq_vol), $sampled(nz_vol),
                                 $sampled(sq_vol + nz_vol), $sampled(so2)));

   mix_varies: assert property (@(posedge clk) disable iff (!arst_n)
      mode == M_MIX && mix_cycles == 64 |-> so2_changes > 0 && nz_heard)
      else report_fail("so2 kept a single value or never carried the noise over 64 cycles");

   so1_gated: assert property (@(posedge clk) disable iff (!arst_n)
      !(shadow[NR52_I][7] && shadow[NR50_I][3]) |=> so1 == '0)
      else report_fail($sformatf("FAIL so1 expected 00 actual %h", $sampled(so1)));

   so2_gated: assert property (@(posedge clk) disable iff (!arst_n)
      !(shadow[NR52_I][7] && shadow[NR50_I][7]) |=> so2 == '0)
      else report_fail($sformatf("FAIL so2 expected 00 actual %h", $sampled(so2)));

   idle_silent: assert property (@(posedge clk) disable iff (!arst_n)
      !sq_on_m && !nz_on_m |=> so1 == '0 && so2 == '0)
      else report_fail($sformatf("FAIL so1 so2 expected 00 00 actual %h %h",
                                 $sampled(so1), $sampled(so2)));

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic axi_write(input reg_addr_t addr, input logic [7:0] data,
                            input logic [3:0] strb);
      int   holds;
      logic take;
      awaddr  = addr;
      wdata   = {24'h000000, data};
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      do begin
         take = awready && wready;
         next_cycle();
      end while (!take);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      holds   = $unsigned($random(seed)) % 4;
      repeat (holds) next_cycle();
      bready = 1'b1;
      do begin
         take = bvalid;
         next_cycle();
      end while (!take);
      bready = 1'b0;
   endtask

   task automatic axi_read(input reg_addr_t addr);
      int   holds;
      logic take;
      araddr  = addr;
      arvalid = 1'b1;
      do begin
         take = arready;
         next_cycle();
      end while (!take);
      arvalid = 1'b0;
      holds   = $unsigned($random(seed)) % 4;
      repeat (holds) next_cycle();
      rready = 1'b1;
      do begin
         take = rvalid;
         next_cycle();
      end while (!take);
      rready = 1'b0;
   endtask

   // Retrigger the square and watch four of its periods on so1.
   task automatic run_square(input logic [7:0] period, input logic [7:0] ctrl);
      mode = M_IDLE;
      axi_write(`SND_SQ_PERIOD, period, 4'h1);
      axi_write(`SND_SQ_CTRL, ctrl, 4'h1);
      mode = M_SQUARE;
      repeat (32 * (int'(period) + 1) + 10) next_cycle();
      mode = M_IDLE;
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      report_fail($sformatf("Timeout, the tests did not finish within %0d clock cycles",
                            WATCHDOG_CYCLES));
   end

   initial begin
      logic [7:0] data;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      mode    = M_IDLE;
      @(posedge arst_n);
      next_cycle();

      // Round trip, channels stay untriggered.
      for (int i = 0; i < 9; i++) begin
         data = $random(seed);
         if (i == SQ_CTRL_I || i == NZ_CTRL_I) begin
            data[7] = 1'b0;
         end
         axi_write(reg_addr_t'(i * 4), data, 4'h1);
         axi_read(reg_addr_t'(i * 4));
      end
      axi_write(8'h24, 8'h5A, 4'h1);
      axi_read(8'h24);
      axi_read(8'h02);
      axi_read(8'hFC);
      axi_write(`SND_NR51, 8'hAA, 4'h0);
      axi_read(`SND_NR51);
      axi_write(`SND_SQ_LEN, 8'h00, 4'h1);
      axi_write(`SND_NZ_LEN, 8'h00, 4'h1);

      // Square alone on so1, noise running but unrouted.
      axi_write(`SND_NR52, 8'h80, 4'h1);
      axi_write(`SND_NR50, 8'h08, 4'h1);
      axi_write(`SND_NR51, 8'h01, 4'h1);
      axi_write(`SND_NZ_PERIOD, 8'h00, 4'h1);
      axi_write(`SND_NZ_CTRL, 8'h87, 4'h1);
      run_square(8'h03, 8'hA9);
      run_square(8'h01, 8'h85);
      run_square(8'h00, 8'hB4);

      // Both channels on so2.
      axi_write(`SND_NR51, 8'h31, 4'h1);
      axi_write(`SND_NR50, 8'h88, 4'h1);
      axi_write(`SND_SQ_PERIOD, 8'h01, 4'h1);
      axi_write(`SND_SQ_CTRL, 8'h93, 4'h1);
      axi_write(`SND_NZ_CTRL, 8'h8A, 4'h1);
      mode = M_MIX;
      repeat (80) next_cycle();

      // Gating by NR50 then by the master enable.
      axi_write(`SND_NR50, 8'h08, 4'h1);
      repeat (5) next_cycle();
      axi_write(`SND_NR50, 8'h80, 4'h1);
      repeat (5) next_cycle();
      axi_write(`SND_NR50, 8'h88, 4'h1);
      axi_write(`SND_NR52, 8'h00, 4'h1);
      repeat (5) next_cycle();
      axi_write(`SND_NR52, 8'h80, 4'h1);
      mode = M_IDLE;

      // Length counters and NR52 status.
      axi_write(`SND_SQ_PERIOD, 8'h04, 4'h1);
      axi_write(`SND_SQ_LEN, 8'h05, 4'h1);
      axi_write(`SND_NZ_PERIOD, 8'h03, 4'h1);
      axi_write(`SND_NZ_LEN, 8'h06, 4'h1);
      axi_write(`SND_SQ_CTRL, 8'h82, 4'h1);
      axi_write(`SND_NZ_CTRL, 8'h85, 4'h1);
      axi_read(`SND_NR52);
      repeat (40) next_cycle();
      axi_read(`SND_NR52);
      repeat (10) next_cycle();

      $display("Everything OK");
      $finish;
   end

endmodule

// File: flist.f
+incdir+common
common/sound_pkg.sv
common/reg_bus_if.sv
source/sound_regs.sv
square_channel/square_channel.sv
noise_channel/noise_channel.sv
source/sound_mixer.sv
source/sound_controller.sv
verif/clk_gen.sv
verif/sound_tb.sv

// File: Bender.yml
package:
  name: sound_controller

export_include_dirs:
  - common

sources:
  - files:
      - common/sound_pkg.sv
      - common/reg_bus_if.sv
      - source/sound_regs.sv
      - square_channel/square_channel.sv
      - noise_channel/noise_channel.sv
      - source/sound_mixer.sv
      - source/sound_controller.sv
  - target: simulation
    files:
      - verif/clk_gen.sv
      - verif/sound_tb.sv
